/* sources.f */
+incdir+common
common/div_pkg.sv
int_div/div_ctrl.sv
int_div/div_bit_counter.sv
int_div/div_datapath.sv
design/reg_file.sv
design/div_regfile_top.sv
testbench/div_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the divider testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module div_tb -f sources.f \
    -o div_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/div_sim > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All checks passed" sim.log && echo "simulation ok" || { echo "no pass line found"; exit 1; }

/* testbench/div_tb.sv */
// ======================================================================
// directed testbench for the divider with register file writeback
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "div_cfg.svh"

module div_tb;

    // waits give up after this many cycles
    localparam int timeout_cycles = 2 * `DIV_DATA_WIDTH + 20;

    logic           clk;
    logic           rst;
    logic           req_valid;
    logic           req_ready;
    div_pkg::data_t a;
    div_pkg::data_t b;
    div_pkg::sel_t  quot_sel;
    div_pkg::sel_t  mod_sel;
    div_pkg::sel_t  rd_sel;
    div_pkg::data_t rd_data;

    // expected register contents
    div_pkg::data_t shadow [0:`DIV_NUM_REGS-1];

    div_regfile_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .a         (a),
        .b         (b),
        .quot_sel  (quot_sel),
        .mod_sel   (mod_sel),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_val(input string name, input div_pkg::data_t got,
                             input div_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // restoring rule with a zero divisor gives all ones and the dividend
    function automatic div_pkg::data_t quotient_of(input div_pkg::data_t x,
                                                   input div_pkg::data_t y);
        if (y == '0) begin
            return '1;
        end
        return x / y;
    endfunction

    function automatic div_pkg::data_t remainder_of(input div_pkg::data_t x,
                                                    input div_pkg::data_t y);
        if (y == '0) begin
            return x;
        end
        return x % y;
    endfunction

    function automatic div_pkg::sel_t pick_selector();
        return div_pkg::sel_t'(1 + ($urandom % (`DIV_NUM_REGS - 1)));
    endfunction

    // drive rd_sel on the edge, sample the combinational read mid-cycle
    task automatic read_reg(input div_pkg::sel_t sel, output div_pkg::data_t val);
        @(posedge clk);
        rd_sel <= sel;
        @(negedge clk);
        val = rd_data;
    endtask

    task automatic compare_all_regs();
        div_pkg::data_t val;
        for (int i = 0; i < `DIV_NUM_REGS; i++) begin
            read_reg(div_pkg::sel_t'(i), val);
            check_val($sformatf("reg[%0d]", i), val, shadow[i]);
        end
    endtask

    // request, accept, then wait for req_ready to come back
    task automatic issue_div(input div_pkg::data_t x, input div_pkg::data_t y,
                             input div_pkg::sel_t qs, input div_pkg::sel_t ms);
        int cycles;
        @(posedge clk);
        req_valid <= 1'b1;
        a         <= x;
        b         <= y;
        quot_sel  <= qs;
        mod_sel   <= ms;
        cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timeout: request was never accepted");
            end
            @(negedge clk);
        end
        // accept edge, then scramble operands to prove they were latched
        @(posedge clk);
        req_valid <= 1'b0;
        a         <= div_pkg::data_t'($urandom);
        b         <= div_pkg::data_t'($urandom);
        quot_sel  <= pick_selector();
        mod_sel   <= pick_selector();
        cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timeout: divider did not return to ready");
            end
            @(negedge clk);
        end
    endtask

    task automatic run_division(input div_pkg::data_t x, input div_pkg::data_t y,
                                input div_pkg::sel_t qs, input div_pkg::sel_t ms,
                                input bit full_check);
        div_pkg::data_t val;
        issue_div(x, y, qs, ms);
        // selector zero means no write
        if (qs != '0) begin
            shadow[qs] = quotient_of(x, y);
        end
        if (ms != '0) begin
            shadow[ms] = remainder_of(x, y);
        end
        if (full_check) begin
            compare_all_regs();
        end else begin
            read_reg(qs, val);
            check_val("quotient reg", val, shadow[qs]);
            read_reg(ms, val);
            check_val("remainder reg", val, shadow[ms]);
        end
    endtask

    task automatic after_reset_state();
        @(negedge clk);
        check_val("req_ready", div_pkg::data_t'(req_ready), div_pkg::data_t'(1));
        compare_all_regs();
    endtask

    task automatic directed_divisions();
        // exact multiple, small dividend, divisor 1, equal operands
        run_division(32'd100, 32'd10, 5'd1, 5'd2, 1'b1);
        run_division(32'd7, 32'd20, 5'd3, 5'd4, 1'b1);
        run_division(32'd12345, 32'd1, 5'd5, 5'd6, 1'b1);
        run_division(32'd999, 32'd999, 5'd7, 5'd8, 1'b1);
        run_division(32'd1000, 32'd7, 5'd9, 5'd10, 1'b1);
        run_division(32'hffff_ffff, 32'd16, 5'd11, 5'd12, 1'b1);
    endtask

    task automatic zero_selector_writes();
        run_division(32'd500, 32'd3, 5'd0, 5'd13, 1'b1);
        run_division(32'd501, 32'd4, 5'd14, 5'd0, 1'b1);
        // nothing written, only ready comes back
        run_division(32'd777, 32'd5, 5'd0, 5'd0, 1'b1);
    endtask

    task automatic reg0_and_zero_divisor();
        div_pkg::data_t val;
        run_division(32'd77, 32'd5, 5'd0, 5'd15, 1'b1);
        read_reg('0, val);
        check_val("reg[0]", val, '0);
        run_division(32'h1234_5678, 32'd0, 5'd16, 5'd17, 1'b1);
        run_division(32'd0, 32'd0, 5'd18, 5'd19, 1'b1);
    endtask

    task automatic back_to_back_random();
        div_pkg::data_t x;
        div_pkg::data_t y;
        div_pkg::sel_t  qs;
        div_pkg::sel_t  ms;
        for (int n = 0; n < 20; n++) begin
            x  = div_pkg::data_t'($urandom);
            // vary divisor magnitude so quotients span many widths
            y  = div_pkg::data_t'($urandom >> ($urandom % 32));
            qs = pick_selector();
            ms = pick_selector();
            while (ms == qs) begin
                ms = pick_selector();
            end
            run_division(x, y, qs, ms, 1'b0);
        end
        compare_all_regs();
    endtask

    initial begin
        void'($urandom(65));
        rst       <= 1'b1;
        req_valid <= 1'b0;
        a         <= '0;
        b         <= '0;
        quot_sel  <= '0;
        mod_sel   <= '0;
        rd_sel    <= '0;
        for (int i = 0; i < `DIV_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        after_reset_state();
        directed_divisions();
        zero_selector_writes();
        reg0_and_zero_divisor();
        back_to_back_random();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/div_regfile_top.sv */
// ======================================================================
// divider top: controller, bit counter, datapath and register file
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "div_cfg.svh"

module div_regfile_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           req_valid,
    output logic           req_ready,
    input  div_pkg::data_t a,
    input  div_pkg::data_t b,
    input  div_pkg::sel_t  quot_sel,
    input  div_pkg::sel_t  mod_sel,
    input  div_pkg::sel_t  rd_sel,
    output div_pkg::data_t rd_data
);

    // controller to counter and datapath
    logic           start;
    logic           step;
    logic           last;
    div_pkg::pos_t  pos;
    div_pkg::data_t quotient;
    div_pkg::data_t remainder;

    // write port between controller and register file
    logic           rf_wr_req;
    div_pkg::sel_t  rf_wr_sel;
    div_pkg::data_t rf_wr_data;
    logic           rf_wr_ack;

    div_ctrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .quot_sel   (quot_sel),
        .mod_sel    (mod_sel),
        .start      (start),
        .step       (step),
        .last       (last),
        .quotient   (quotient),
        .remainder  (remainder),
        .rf_wr_req  (rf_wr_req),
        .rf_wr_sel  (rf_wr_sel),
        .rf_wr_data (rf_wr_data),
        .rf_wr_ack  (rf_wr_ack)
    );

    div_bit_counter cnt0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .step  (step),
        .pos   (pos),
        .last  (last)
    );

    // operands go straight in, the datapath latches them on start
    div_datapath dp0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .step      (step),
        .pos       (pos),
        .a         (a),
        .b         (b),
        .quotient  (quotient),
        .remainder (remainder)
    );

    reg_file rf0 (
        .clk     (clk),
        .rst     (rst),
        .wr_req  (rf_wr_req),
        .wr_sel  (rf_wr_sel),
        .wr_data (rf_wr_data),
        .wr_ack  (rf_wr_ack),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* design/reg_file.sv */
// ======================================================================
// register file: req/ack write port, combinational read, zero register
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "div_cfg.svh"

module reg_file (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_req,
    input  div_pkg::sel_t  wr_sel,
    input  div_pkg::data_t wr_data,
    output logic           wr_ack,
    input  div_pkg::sel_t  rd_sel,
    output div_pkg::data_t rd_data
);

    // register 0 has no storage
    div_pkg::data_t regs [1:`DIV_NUM_REGS-1];

    // a request not yet acked, served on this edge
    logic new_req;

    assign new_req = wr_req && !wr_ack;

    // ack pulses for one cycle after each new request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= new_req;
        end
    end

    // write lands on the same edge that raises ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `DIV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (new_req && (wr_sel != '0)) begin
            // writes to register 0 are dropped
            regs[wr_sel] <= wr_data;
        end
    end

    // combinational read, register 0 hardwired
    always_comb begin
        if (rd_sel == '0) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_sel];
        end
    end

    // client keeps the same write presented through the ack cycle
    a_ack_with_held_req : assert property (
        @(posedge clk) disable iff (rst)
        wr_ack |-> (wr_req && $stable(wr_sel) && $stable(wr_data))
    );

endmodule

`default_nettype wire

/* int_div/div_datapath.sv */
// ======================================================================
// restoring division datapath: divisor, partial remainder and quotient
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "div_cfg.svh"

module div_datapath (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           step,
    input  div_pkg::pos_t  pos,
    input  div_pkg::data_t a,
    input  div_pkg::data_t b,
    output div_pkg::data_t quotient,
    output div_pkg::data_t remainder
);

    localparam int width = `DIV_DATA_WIDTH;

    // divisor copy, taken at start
    div_pkg::data_t b_q;

    // partial remainder and quotient state
    div_pkg::data_t rem_q;
    div_pkg::data_t quot_q;
    div_pkg::data_t rem_nxt;
    div_pkg::data_t quot_nxt;

    // double width so the shifted divisor never drops high bits
    logic [2*width-1:0] shifted_b;
    logic [2*width-1:0] ext_rem;
    logic               fits;

    assign shifted_b = {{width{1'b0}}, b_q} << pos;
    assign ext_rem   = {{width{1'b0}}, rem_q};

    // equal counts as a fit
    // a zero divisor always fits, so quotient is all ones
    assign fits = (shifted_b <= ext_rem);

    always_comb begin
        rem_nxt  = rem_q;
        quot_nxt = quot_q;
        if (start) begin
            rem_nxt  = a;
            quot_nxt = '0;
        end else if (step && fits) begin
            // fit means shifted_b <= rem, so upper half is zero here
            rem_nxt       = rem_q - shifted_b[width-1:0];
            quot_nxt[pos] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem_q  <= '0;
            quot_q <= '0;
        end else begin
            rem_q  <= rem_nxt;
            quot_q <= quot_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            b_q <= b;
        end
    end

    // outputs show the value the next edge stores, so on the last step
    // the controller sees the finished quotient and remainder
    assign quotient  = quot_nxt;
    assign remainder = rem_nxt;

endmodule

`default_nettype wire

/* int_div/div_bit_counter.sv */
// ======================================================================
// quotient bit position down-counter with last-step flag
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "div_cfg.svh"

module div_bit_counter (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          step,
    output div_pkg::pos_t pos,
    output logic          last
);

    // msb index, first bit resolved
    localparam div_pkg::pos_t top_pos = div_pkg::pos_t'(`DIV_DATA_WIDTH - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= '0;
        end else if (start) begin
            pos <= top_pos;
        end else if (step) begin
            // moves down one bit per step
            pos <= pos - div_pkg::pos_t'(1);
        end
    end

    // bit 0 is the final step of a division
    assign last = (pos == '0);

    // once bit 0 has been stepped the controller stops stepping
    // until a new start reloads the position
    a_no_step_past_zero : assert property (
        @(posedge clk) disable iff (rst)
        (step && last) |=> !step
    );

endmodule

`default_nettype wire

/* int_div/div_ctrl.sv */
// ======================================================================
// divider controller FSM: request accept, calc stepping, result writes
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "div_cfg.svh"

module div_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           req_valid,
    output logic           req_ready,
    input  div_pkg::sel_t  quot_sel,
    input  div_pkg::sel_t  mod_sel,
    output logic           start,
    output logic           step,
    input  logic           last,
    input  div_pkg::data_t quotient,
    input  div_pkg::data_t remainder,
    output logic           rf_wr_req,
    output div_pkg::sel_t  rf_wr_sel,
    output div_pkg::data_t rf_wr_data,
    input  logic           rf_wr_ack
);

    div_pkg::div_state_e state;

    // destination selectors captured at acceptance
    div_pkg::sel_t quot_sel_q;
    div_pkg::sel_t mod_sel_q;

    // entry conditions for the two write states
    logic enter_quot;
    logic enter_mod;

    // ready only while nothing is in flight
    assign req_ready = (state == div_pkg::idle);

    // one-cycle pulse on the accept edge
    assign start = req_valid && req_ready;

    // calc advances one quotient bit every clock
    assign step = (state == div_pkg::calc);

    // quotient write goes first whenever its selector is non-zero
    assign enter_quot = step && last && (quot_sel_q != '0);

    // remainder write follows the last step directly when the quotient
    // write is skipped, otherwise it follows the quotient ack
    assign enter_mod = (mod_sel_q != '0) &&
                       ((step && last && (quot_sel_q == '0)) ||
                        ((state == div_pkg::write_quot) && rf_wr_ack));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= div_pkg::idle;
            quot_sel_q <= '0;
            mod_sel_q  <= '0;
            rf_wr_req  <= 1'b0;
            rf_wr_sel  <= '0;
        end else begin
            case (state)
                div_pkg::idle: begin
                    if (start) begin
                        quot_sel_q <= quot_sel;
                        mod_sel_q  <= mod_sel;
                        state      <= div_pkg::calc;
                    end
                end
                div_pkg::calc: begin
                    if (last) begin
                        if (enter_quot) begin
                            rf_wr_req <= 1'b1;
                            rf_wr_sel <= quot_sel_q;
                            state     <= div_pkg::write_quot;
                        end else if (enter_mod) begin
                            rf_wr_req <= 1'b1;
                            rf_wr_sel <= mod_sel_q;
                            state     <= div_pkg::write_mod;
                        end else begin
                            // both selectors zero, nothing to write
                            state <= div_pkg::idle;
                        end
                    end
                end
                div_pkg::write_quot: begin
                    if (rf_wr_ack) begin
                        if (enter_mod) begin
                            // request stays high, only selector and data change
                            rf_wr_sel <= mod_sel_q;
                            state     <= div_pkg::write_mod;
                        end else begin
                            rf_wr_req <= 1'b0;
                            state     <= div_pkg::idle;
                        end
                    end
                end
                div_pkg::write_mod: begin
                    if (rf_wr_ack) begin
                        rf_wr_req <= 1'b0;
                        state     <= div_pkg::idle;
                    end
                end
                default: begin
                    state <= div_pkg::idle;
                end
            endcase
        end
    end

    // write data register
    // datapath outputs already carry the final values on the last step
    always_ff @(posedge clk) begin
        if (enter_quot) begin
            rf_wr_data <= quotient;
        end else if (enter_mod) begin
            rf_wr_data <= remainder;
        end
    end

    // request held with the same selector until the register file acks
    a_wr_req_hold : assert property (
        @(posedge clk) disable iff (rst)
        (rf_wr_req && !rf_wr_ack) |=> (rf_wr_req && $stable(rf_wr_sel))
    );

    // no write handshake in progress while quotient bits are stepped
    a_step_port_idle : assert property (
        @(posedge clk) disable iff (rst)
        step |-> (!rf_wr_req && !rf_wr_ack)
    );

endmodule

`default_nettype wire

/* common/div_pkg.sv */
// ======================================================================
// shared divider types: data, selector, bit position and FSM states
// ======================================================================
`default_nettype none

`include "div_cfg.svh"

package div_pkg;

    // operands, results and register contents
    typedef logic [`DIV_DATA_WIDTH-1:0] data_t;

    // register selector, zero means no write
    typedef logic [`DIV_SEL_WIDTH-1:0] sel_t;

    // quotient bit currently being resolved
    typedef logic [`DIV_POS_WIDTH-1:0] pos_t;

    // controller states
    // idle waits for a request, calc runs one bit per clock,
    // the two write states each hold one register-file write
    typedef enum logic [1:0] {
        idle       = 2'd0,
        calc       = 2'd1,
        write_quot = 2'd2,
        write_mod  = 2'd3
    } div_state_e;

endpackage

`default_nettype wire

/* common/div_cfg.svh */
// ======================================================================
// divider and register file sizing macros with derived widths
// ======================================================================
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand, quotient and remainder width
`define DIV_DATA_WIDTH 32

// registers in the register file, register 0 included
`define DIV_NUM_REGS 32

// register selector width
`define DIV_SEL_WIDTH ($clog2(`DIV_NUM_REGS))

// quotient bit index width
`define DIV_POS_WIDTH ($clog2(`DIV_DATA_WIDTH))

`endif
